//--- hw/mat_consts.svh
/*
 * Sizes, widths and cycle counts of the 4x4 systolic matrix multiplier
 */
`ifndef MAT_CONSTS_SVH
`define MAT_CONSTS_SVH

// Matrix side and element width
`define MAT_MUL_SIZE 4
`define DWIDTH 8

// Memory geometry with one write enable bit per lane
`define AWIDTH 7
`define ADDR_STRIDE_WIDTH 8
`define MASK_WIDTH 4
`define RAM_DEPTH 128

`define CNT_WIDTH 8
`define NUM_CYCLES_IN_MAC 1

// Read latency, operand words, skew stages, mesh hops and the MAC stage
`define CYCLES_FOR_MATMUL (1 + 3 * (`MAT_MUL_SIZE - 1) + `NUM_CYCLES_IN_MAC)

`endif

//--- hw/mat_pkg.sv
/*
 * Shared types, state encodings and address helper of the matrix multiplier
 */
`include "mat_consts.svh"

package mat_pkg;

    typedef logic [`DWIDTH-1:0] data_t;
    // Four lanes per word with lane 0 in the low bits
    typedef logic [`MAT_MUL_SIZE*`DWIDTH-1:0] word_t;
    typedef logic [`AWIDTH-1:0] addr_t;
    typedef logic [`ADDR_STRIDE_WIDTH-1:0] stride_t;
    typedef logic [`MASK_WIDTH-1:0] mask_t;
    typedef logic [`CNT_WIDTH-1:0] cnt_t;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_COMPUTE, CTRL_WRITE} ctrl_state_e;
    typedef enum logic {OUT_IDLE, OUT_WRITE} out_state_e;

    // Base plus index times stride, wrapping at the memory depth
    function automatic addr_t strided_addr(addr_t base, stride_t stride, stride_t index);
        stride_t offset;
        offset = stride_t'(stride * index);
        return addr_t'(base + addr_t'(offset));
    endfunction

endpackage

//--- hw/mat_ram.sv
/*
 * Dual-port matrix memory with registered reads and lane-masked writes
 */
`include "mat_consts.svh"

module mat_ram (
    input  logic                   clk,
    input  logic [`AWIDTH-1:0]     addr0,
    input  logic [`AWIDTH-1:0]     addr1,
    input  mat_pkg::word_t         d0,
    input  mat_pkg::word_t         d1,
    input  logic [`MASK_WIDTH-1:0] we0,
    input  logic [`MASK_WIDTH-1:0] we1,
    output mat_pkg::word_t         q0,
    output mat_pkg::word_t         q1
);
    import mat_pkg::*;

    word_t mem [`RAM_DEPTH];

    // Port 1 is applied last, so it wins when both ports hit the same lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MASK_WIDTH; i++) begin
            if (we0[i]) begin
                mem[addr0][i*`DWIDTH +: `DWIDTH] <= d0[i*`DWIDTH +: `DWIDTH];
            end
            if (we1[i]) begin
                mem[addr1][i*`DWIDTH +: `DWIDTH] <= d1[i*`DWIDTH +: `DWIDTH];
            end
        end
        // Reads return the word held before this edge's write
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

//--- hw/processing_element.sv
/*
 * Systolic MAC cell: passes A right and B down, accumulates A times B mod 256
 */
module processing_element (
    input  logic           clk,
    input  logic           reset,
    input  logic           clear,
    input  mat_pkg::data_t in_a,
    input  mat_pkg::data_t in_b,
    output mat_pkg::data_t out_a,
    output mat_pkg::data_t out_b,
    output mat_pkg::data_t out_c
);
    import mat_pkg::*;

    data_t product;

    // Only the low byte of the product matters for the wrapping sum
    assign product = data_t'(in_a * in_b);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            out_a <= '0;
            out_b <= '0;
            out_c <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
            out_c <= out_c + product;
        end
    end

endmodule

//--- hw/systolic_pe_matrix.sv
/*
 * 4x4 mesh of MAC cells, A flows along rows and B down the columns
 */
`include "mat_consts.svh"

module systolic_pe_matrix (
    input  logic           clk,
    input  logic           reset,
    input  logic           clear,
    input  mat_pkg::word_t a_skewed,
    input  mat_pkg::word_t b_skewed,
    output mat_pkg::data_t results [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1]
);
    import mat_pkg::*;

    // a_h[i][j] and b_v[i][j] are the operands entering cell (i, j)
    data_t a_h [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1];
    data_t b_v [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1];

    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_edge
        assign a_h[i][0] = a_skewed[i*`DWIDTH +: `DWIDTH];
        assign b_v[0][i] = b_skewed[i*`DWIDTH +: `DWIDTH];
    end

    // Row 0
    processing_element pe00 (.clk, .reset, .clear, .in_a(a_h[0][0]), .in_b(b_v[0][0]),
                             .out_a(a_h[0][1]), .out_b(b_v[1][0]), .out_c(results[0][0]));
    processing_element pe01 (.clk, .reset, .clear, .in_a(a_h[0][1]), .in_b(b_v[0][1]),
                             .out_a(a_h[0][2]), .out_b(b_v[1][1]), .out_c(results[0][1]));
    processing_element pe02 (.clk, .reset, .clear, .in_a(a_h[0][2]), .in_b(b_v[0][2]),
                             .out_a(a_h[0][3]), .out_b(b_v[1][2]), .out_c(results[0][2]));
    processing_element pe03 (.clk, .reset, .clear, .in_a(a_h[0][3]), .in_b(b_v[0][3]),
                             .out_a(), .out_b(b_v[1][3]), .out_c(results[0][3]));

    // Row 1
    processing_element pe10 (.clk, .reset, .clear, .in_a(a_h[1][0]), .in_b(b_v[1][0]),
                             .out_a(a_h[1][1]), .out_b(b_v[2][0]), .out_c(results[1][0]));
    processing_element pe11 (.clk, .reset, .clear, .in_a(a_h[1][1]), .in_b(b_v[1][1]),
                             .out_a(a_h[1][2]), .out_b(b_v[2][1]), .out_c(results[1][1]));
    processing_element pe12 (.clk, .reset, .clear, .in_a(a_h[1][2]), .in_b(b_v[1][2]),
                             .out_a(a_h[1][3]), .out_b(b_v[2][2]), .out_c(results[1][2]));
    processing_element pe13 (.clk, .reset, .clear, .in_a(a_h[1][3]), .in_b(b_v[1][3]),
                             .out_a(), .out_b(b_v[2][3]), .out_c(results[1][3]));

    // Row 2
    processing_element pe20 (.clk, .reset, .clear, .in_a(a_h[2][0]), .in_b(b_v[2][0]),
                             .out_a(a_h[2][1]), .out_b(b_v[3][0]), .out_c(results[2][0]));
    processing_element pe21 (.clk, .reset, .clear, .in_a(a_h[2][1]), .in_b(b_v[2][1]),
                             .out_a(a_h[2][2]), .out_b(b_v[3][1]), .out_c(results[2][1]));
    processing_element pe22 (.clk, .reset, .clear, .in_a(a_h[2][2]), .in_b(b_v[2][2]),
                             .out_a(a_h[2][3]), .out_b(b_v[3][2]), .out_c(results[2][2]));
    processing_element pe23 (.clk, .reset, .clear, .in_a(a_h[2][3]), .in_b(b_v[2][3]),
                             .out_a(), .out_b(b_v[3][3]), .out_c(results[2][3]));

    // Row 3 has no cell below it
    processing_element pe30 (.clk, .reset, .clear, .in_a(a_h[3][0]), .in_b(b_v[3][0]),
                             .out_a(a_h[3][1]), .out_b(), .out_c(results[3][0]));
    processing_element pe31 (.clk, .reset, .clear, .in_a(a_h[3][1]), .in_b(b_v[3][1]),
                             .out_a(a_h[3][2]), .out_b(), .out_c(results[3][1]));
    processing_element pe32 (.clk, .reset, .clear, .in_a(a_h[3][2]), .in_b(b_v[3][2]),
                             .out_a(a_h[3][3]), .out_b(), .out_c(results[3][2]));
    processing_element pe33 (.clk, .reset, .clear, .in_a(a_h[3][3]), .in_b(b_v[3][3]),
                             .out_a(), .out_b(), .out_c(results[3][3]));

endmodule

//--- hw/systolic_data_setup.sv
/*
 * Operand fetch for the mesh: strided A and B reads and the triangular skew
 */
`include "mat_consts.svh"

module systolic_data_setup (
    input  logic             clk,
    input  logic             reset,
    input  logic             start_mat_mul,
    input  logic             clear,
    input  mat_pkg::addr_t   address_mat_a,
    input  mat_pkg::addr_t   address_mat_b,
    input  mat_pkg::stride_t address_stride_a,
    input  mat_pkg::stride_t address_stride_b,
    input  mat_pkg::word_t   a_data,
    input  mat_pkg::word_t   b_data,
    output mat_pkg::addr_t   a_addr,
    output mat_pkg::addr_t   b_addr,
    output mat_pkg::word_t   a_skewed,
    output mat_pkg::word_t   b_skewed
);
    import mat_pkg::*;

    localparam int KW = $clog2(`MAT_MUL_SIZE);

    logic [KW-1:0] k_cnt;
    logic          busy;
    logic          rd_issue;
    logic          rd_valid;
    word_t         a_live;
    word_t         b_live;

    //////////////////////////////
    // Read sequencing
    //////////////////////////////

    // k_cnt sits at zero between runs, so the clear cycle already reads k = 0
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            k_cnt <= '0;
            busy  <= 1'b0;
        end else if (clear) begin
            k_cnt <= KW'(1);
            busy  <= 1'b1;
        end else if (busy) begin
            if (k_cnt == KW'(`MAT_MUL_SIZE - 1)) begin
                busy <= 1'b0;
            end
            k_cnt <= k_cnt + 1'b1;
        end
    end

    assign rd_issue = clear | busy;
    assign a_addr = strided_addr(address_mat_a, address_stride_a, stride_t'(k_cnt));
    assign b_addr = strided_addr(address_mat_b, address_stride_b, stride_t'(k_cnt));

    // Memory data shows up one cycle after its address
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_issue;
        end
    end

    // Zeros outside the window keep later accumulations unchanged
    assign a_live = rd_valid ? a_data : '0;
    assign b_live = rd_valid ? b_data : '0;

    //////////////////////////////
    // Skew where lane i waits i cycles
    //////////////////////////////
    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign a_skewed[0 +: `DWIDTH] = a_live[0 +: `DWIDTH];
            assign b_skewed[0 +: `DWIDTH] = b_live[0 +: `DWIDTH];
        end else begin : g_delay
            data_t a_pipe [0:i-1];
            data_t b_pipe [0:i-1];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int d = 0; d < i; d++) begin
                        a_pipe[d] <= '0;
                        b_pipe[d] <= '0;
                    end
                end else begin
                    a_pipe[0] <= a_live[i*`DWIDTH +: `DWIDTH];
                    b_pipe[0] <= b_live[i*`DWIDTH +: `DWIDTH];
                    for (int d = 1; d < i; d++) begin
                        a_pipe[d] <= a_pipe[d-1];
                        b_pipe[d] <= b_pipe[d-1];
                    end
                end
            end

            assign a_skewed[i*`DWIDTH +: `DWIDTH] = a_pipe[i-1];
            assign b_skewed[i*`DWIDTH +: `DWIDTH] = b_pipe[i-1];
        end
    end

endmodule

//--- hw/matmul_output_logic.sv
/*
 * Result drain: captures the accumulators and writes C one row per cycle
 */
`include "mat_consts.svh"

module matmul_output_logic (
    input  logic             clk,
    input  logic             reset,
    input  logic             compute_done,
    input  mat_pkg::addr_t   address_mat_c,
    input  mat_pkg::stride_t address_stride_c,
    input  mat_pkg::data_t   results [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1],
    output mat_pkg::addr_t   c_addr,
    output mat_pkg::word_t   c_data,
    output mat_pkg::mask_t   c_we,
    output logic             write_done
);
    import mat_pkg::*;

    localparam int RW = $clog2(`MAT_MUL_SIZE);

    out_state_e    state;
    logic [RW-1:0] row;
    logic          last_row;
    data_t         c_hold [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1];

    assign last_row = (row == RW'(`MAT_MUL_SIZE - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= OUT_IDLE;
            row   <= '0;
        end else begin
            case (state)
                OUT_IDLE: begin
                    row <= '0;
                    if (compute_done) begin
                        state <= OUT_WRITE;
                    end
                end
                OUT_WRITE: begin
                    row <= row + 1'b1;
                    if (last_row) begin
                        state <= OUT_IDLE;
                    end
                end
                default: state <= OUT_IDLE;
            endcase
        end
    end

    // Snapshot so the mesh is free as soon as compute ends
    always_ff @(posedge clk) begin
        if (state == OUT_IDLE && compute_done) begin
            c_hold <= results;
        end
    end

    always_comb begin
        for (int j = 0; j < `MAT_MUL_SIZE; j++) begin
            c_data[j*`DWIDTH +: `DWIDTH] = c_hold[row][j];
        end
    end

    assign c_addr     = strided_addr(address_mat_c, address_stride_c, stride_t'(row));
    assign c_we       = (state == OUT_WRITE) ? '1 : '0;
    assign write_done = (state == OUT_WRITE) && last_row;

endmodule

//--- hw/matrix_multiplication.sv
/*
 * 4x4 systolic matrix multiplier with A, B and C memories and run control
 */
`include "mat_consts.svh"

module matrix_multiplication (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  mat_pkg::addr_t   address_mat_a,
    input  mat_pkg::addr_t   address_mat_b,
    input  mat_pkg::addr_t   address_mat_c,
    input  mat_pkg::stride_t address_stride_a,
    input  mat_pkg::stride_t address_stride_b,
    input  mat_pkg::stride_t address_stride_c,
    input  mat_pkg::addr_t   bram_addr_a_ext,
    input  mat_pkg::addr_t   bram_addr_b_ext,
    input  mat_pkg::addr_t   bram_addr_c_ext,
    input  mat_pkg::word_t   bram_wdata_a_ext,
    input  mat_pkg::word_t   bram_wdata_b_ext,
    input  mat_pkg::word_t   bram_wdata_c_ext,
    input  mat_pkg::mask_t   bram_we_a_ext,
    input  mat_pkg::mask_t   bram_we_b_ext,
    input  mat_pkg::mask_t   bram_we_c_ext,
    output mat_pkg::word_t   bram_rdata_a_ext,
    output mat_pkg::word_t   bram_rdata_b_ext,
    output mat_pkg::word_t   bram_rdata_c_ext,
    output logic             done
);
    import mat_pkg::*;

    ctrl_state_e state;
    cnt_t        cycle_cnt;
    logic        start_mat_mul;
    logic        clear;
    logic        compute_done;
    logic        write_done;

    addr_t bram_addr_a;
    addr_t bram_addr_b;
    addr_t bram_addr_c;
    word_t bram_rdata_a;
    word_t bram_rdata_b;
    word_t bram_wdata_c;
    mask_t bram_we_c;
    word_t a_skewed;
    word_t b_skewed;
    data_t results [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1];

    //////////////////////////////
    // Memories
    //////////////////////////////

    // Port 0 belongs to the datapath, port 1 to the host
    mat_ram matrix_a (.clk, .addr0(bram_addr_a), .d0('0), .we0('0), .q0(bram_rdata_a),
                      .addr1(bram_addr_a_ext), .d1(bram_wdata_a_ext), .we1(bram_we_a_ext),
                      .q1(bram_rdata_a_ext));
    mat_ram matrix_b (.clk, .addr0(bram_addr_b), .d0('0), .we0('0), .q0(bram_rdata_b),
                      .addr1(bram_addr_b_ext), .d1(bram_wdata_b_ext), .we1(bram_we_b_ext),
                      .q1(bram_rdata_b_ext));
    mat_ram matrix_c (.clk, .addr0(bram_addr_c), .d0(bram_wdata_c), .we0(bram_we_c), .q0(),
                      .addr1(bram_addr_c_ext), .d1(bram_wdata_c_ext), .we1(bram_we_c_ext),
                      .q1(bram_rdata_c_ext));

    //////////////////////////////
    // Run control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= CTRL_IDLE;
            start_mat_mul <= 1'b0;
            clear         <= 1'b0;
            done          <= 1'b0;
        end else begin
            clear <= 1'b0;
            done  <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (start) begin
                        state         <= CTRL_COMPUTE;
                        start_mat_mul <= 1'b1;
                        clear         <= 1'b1;
                    end
                end
                CTRL_COMPUTE: begin
                    if (compute_done) begin
                        state <= CTRL_WRITE;
                    end
                end
                CTRL_WRITE: begin
                    // done follows the last row write by one cycle
                    if (write_done) begin
                        state         <= CTRL_IDLE;
                        start_mat_mul <= 1'b0;
                        done          <= 1'b1;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // The last product lands in the bottom-right cell at this count
    assign compute_done = (state == CTRL_COMPUTE) &&
                          (cycle_cnt == cnt_t'(`CYCLES_FOR_MATMUL));

    //////////////////////////////
    // Datapath
    //////////////////////////////
    systolic_data_setup u_systolic_data_setup (
        .clk, .reset, .start_mat_mul, .clear,
        .address_mat_a, .address_mat_b, .address_stride_a, .address_stride_b,
        .a_data(bram_rdata_a), .b_data(bram_rdata_b),
        .a_addr(bram_addr_a), .b_addr(bram_addr_b),
        .a_skewed, .b_skewed
    );

    systolic_pe_matrix u_systolic_pe_matrix (
        .clk, .reset, .clear, .a_skewed, .b_skewed, .results
    );

    matmul_output_logic u_matmul_output_logic (
        .clk, .reset, .compute_done, .address_mat_c, .address_stride_c, .results,
        .c_addr(bram_addr_c), .c_data(bram_wdata_c), .c_we(bram_we_c), .write_done
    );

endmodule

//--- test/matrix_multiplication_sva.sv
/*
 * Bound checks on run control: done pulse shape and the C write window
 */
module matrix_multiplication_sva (
    input logic           clk,
    input logic           reset,
    input logic           start,
    input logic           start_mat_mul,
    input logic           done,
    input mat_pkg::mask_t bram_we_c
);

    logic run_open;
    logic c_writing;

    assign c_writing = |bram_we_c;

    // Opened by an accepted start, closed by the done of that run
    always_ff @(posedge clk) begin
        if (reset) begin
            run_open <= 1'b0;
        end else if (start && !start_mat_mul) begin
            run_open <= 1'b1;
        end else if (done) begin
            run_open <= 1'b0;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Four row writes, then done with the mask already released
    a_write_window: assert property (@(posedge clk) disable iff (reset)
        $rose(c_writing) |-> c_writing [*4] ##1 (done && !c_writing))
        else $error("C write window is not four cycles followed by done");

    a_done_after_writes: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(c_writing, 1) && $past(c_writing, 4))
        else $error("done without the four preceding C writes");

    a_write_in_run: assert property (@(posedge clk) disable iff (reset)
        c_writing |-> start_mat_mul)
        else $error("C written outside a multiply");

    a_done_needs_start: assert property (@(posedge clk) disable iff (reset)
        done |-> run_open)
        else $error("second done without a new start");

endmodule

bind matrix_multiplication matrix_multiplication_sva u_matrix_multiplication_sva (
    .clk, .reset, .start, .start_mat_mul, .done, .bram_we_c
);

//--- test/tb_matrix_multiplication.sv
/*
 * Testbench for the systolic matrix multiplier: LFSR matrices,
 * a wrapping reference product and exact done latency
 */
`include "mat_consts.svh"

module tb_matrix_multiplication;
    import mat_pkg::*;

    localparam int N = `MAT_MUL_SIZE;
    localparam int LATENCY = 1 + `CYCLES_FOR_MATMUL + 5;
    localparam int NUM_RUNS = 6;
    // Loading, the multiply, the idle checks after done and readback
    localparam int RUN_CYCLES = 2 * N + LATENCY + LATENCY + 2 * N + 4;
    localparam int TIMEOUT_CYCLES = 8 + 40 + NUM_RUNS * RUN_CYCLES + 100;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic    clk = 1'b0;
    logic    reset;
    logic    start;
    addr_t   address_mat_a, address_mat_b, address_mat_c;
    stride_t address_stride_a, address_stride_b, address_stride_c;
    addr_t   bram_addr_a_ext, bram_addr_b_ext, bram_addr_c_ext;
    word_t   bram_wdata_a_ext, bram_wdata_b_ext, bram_wdata_c_ext;
    mask_t   bram_we_a_ext, bram_we_b_ext, bram_we_c_ext;
    word_t   bram_rdata_a_ext, bram_rdata_b_ext, bram_rdata_c_ext;
    logic    done;

    logic [31:0] lfsr_state = 32'h0f4c_cc49;
    int unsigned cycle_count = 0;

    // Reference copy of the current problem
    addr_t   base_a, base_b, base_c;
    stride_t stride_a, stride_b, stride_c;
    data_t   a_mat [N][N];
    data_t   b_mat [N][N];
    data_t   c_exp [N][N];

    matrix_multiplication u_matrix_multiplication (.*);

    always #5 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // One Galois step per bit where the bit shifted out is the random bit
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int n = 0; n < width; n++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    function automatic addr_t layout_addr(input addr_t base, input stride_t stride, input int k);
        return addr_t'((int'(base) + int'(stride) * k) % `RAM_DEPTH);
    endfunction

    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input mask_t m);
        word_t w;
        w = old_w;
        for (int i = 0; i < N; i++) begin
            if (m[i]) begin
                w[i*`DWIDTH +: `DWIDTH] = new_w[i*`DWIDTH +: `DWIDTH];
            end
        end
        return w;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, the run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    //////////////////////////////
    // Host port access
    //////////////////////////////
    task automatic host_write(input addr_t aa, input word_t da, input mask_t ma,
                              input addr_t ab, input word_t db, input mask_t mb,
                              input addr_t ac, input word_t dc, input mask_t mc);
        @(posedge clk);
        bram_addr_a_ext  <= aa;
        bram_wdata_a_ext <= da;
        bram_we_a_ext    <= ma;
        bram_addr_b_ext  <= ab;
        bram_wdata_b_ext <= db;
        bram_we_b_ext    <= mb;
        bram_addr_c_ext  <= ac;
        bram_wdata_c_ext <= dc;
        bram_we_c_ext    <= mc;
        @(posedge clk);
        bram_we_a_ext <= '0;
        bram_we_b_ext <= '0;
        bram_we_c_ext <= '0;
    endtask

    // Leaves the read words stable on the outputs until the next rising edge
    task automatic host_read(input addr_t aa, input addr_t ab, input addr_t ac);
        @(posedge clk);
        bram_addr_a_ext <= aa;
        bram_addr_b_ext <= ab;
        bram_addr_c_ext <= ac;
        @(posedge clk);
        @(negedge clk);
    endtask

    //////////////////////////////
    // Multiply runs
    //////////////////////////////
    task automatic new_problem();
        data_t acc;
        base_a = addr_t'(random_bits(`AWIDTH));
        base_b = addr_t'(random_bits(`AWIDTH));
        base_c = addr_t'(random_bits(`AWIDTH));
        // 4 to 35 words, so four strided words never wrap onto each other
        stride_a = stride_t'(4 + random_bits(5));
        stride_b = stride_t'(4 + random_bits(5));
        stride_c = stride_t'(4 + random_bits(5));
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_mat[i][j] = data_t'(random_bits(`DWIDTH));
                b_mat[i][j] = data_t'(random_bits(`DWIDTH));
            end
        end
        for (int r = 0; r < N; r++) begin
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int k = 0; k < N; k++) begin
                    acc = data_t'(acc + a_mat[r][k] * b_mat[k][j]);
                end
                c_exp[r][j] = acc;
            end
        end
        @(posedge clk);
        address_mat_a    <= base_a;
        address_mat_b    <= base_b;
        address_mat_c    <= base_c;
        address_stride_a <= stride_a;
        address_stride_b <= stride_b;
        address_stride_c <= stride_c;
    endtask

    // C rows are filled with the complement of the answer to catch missed writes
    task automatic load_problem();
        word_t wa, wb, wc;
        for (int k = 0; k < N; k++) begin
            for (int i = 0; i < N; i++) begin
                wa[i*`DWIDTH +: `DWIDTH] = a_mat[i][k];
                wb[i*`DWIDTH +: `DWIDTH] = b_mat[k][i];
                wc[i*`DWIDTH +: `DWIDTH] = c_exp[k][i];
            end
            host_write(layout_addr(base_a, stride_a, k), wa, '1,
                       layout_addr(base_b, stride_b, k), wb, '1,
                       layout_addr(base_c, stride_c, k), ~wc, '1);
        end
    endtask

    // A run started by a stray start would report its done within one latency
    task automatic run_multiply(input int hold_cycles, input int extra_pulse_at);
        int   cycles;
        logic seen;
        @(posedge clk);
        start <= 1'b1;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            cycles++;
            start <= (cycles < hold_cycles) || (cycles == extra_pulse_at);
            @(negedge clk);
            seen = done;
            if (!seen && cycles >= 2 * LATENCY) begin
                fail_run("no done pulse within twice the expected latency");
            end
        end
        check_count("done latency", cnt_t'(cycles), cnt_t'(LATENCY));
        repeat (LATENCY) begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
        end
    endtask

    task automatic verify_product();
        word_t exp_row;
        for (int r = 0; r < N; r++) begin
            for (int j = 0; j < N; j++) begin
                exp_row[j*`DWIDTH +: `DWIDTH] = c_exp[r][j];
            end
            host_read('0, '0, layout_addr(base_c, stride_c, r));
            check_word($sformatf("bram_rdata_c_ext row %0d", r), bram_rdata_c_ext, exp_row);
        end
    endtask

    //////////////////////////////
    // Sequence
    //////////////////////////////
    initial begin
        word_t first;
        word_t second;
        reset = 1'b1;
        start = 1'b0;
        address_mat_a = '0;
        address_mat_b = '0;
        address_mat_c = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        bram_addr_a_ext = '0;
        bram_addr_b_ext = '0;
        bram_addr_c_ext = '0;
        bram_wdata_a_ext = '0;
        bram_wdata_b_ext = '0;
        bram_wdata_c_ext = '0;
        bram_we_a_ext = '0;
        bram_we_b_ext = '0;
        bram_we_c_ext = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Idle with start low, and a plain C write and readback
        repeat (10) begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
        end
        host_write('0, '0, '0, '0, '0, '0, 7'h15, 32'hc0de_5a17, '1);
        host_read('0, '0, 7'h15);
        check_word("bram_rdata_c_ext", bram_rdata_c_ext, 32'hc0de_5a17);

        // Lane masks on the host ports of A and B
        first = random_bits(32);
        second = random_bits(32);
        host_write(7'h22, first, '1, 7'h41, ~first, '1, '0, '0, '0);
        host_write(7'h22, second, 4'b0101, 7'h41, second, 4'b1010, '0, '0, '0);
        host_read(7'h22, 7'h41, '0);
        check_word("bram_rdata_a_ext", bram_rdata_a_ext, merge_lanes(first, second, 4'b0101));
        check_word("bram_rdata_b_ext", bram_rdata_b_ext, merge_lanes(~first, second, 4'b1010));

        // Run 1 holds start for four cycles, run 2 repeats it mid-multiply
        for (int run = 0; run < NUM_RUNS; run++) begin
            new_problem();
            load_problem();
            run_multiply((run == 1) ? 4 : 1, (run == 2) ? 9 : 0);
            verify_product();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/mat_pkg.sv
hw/mat_ram.sv
hw/processing_element.sv
hw/systolic_pe_matrix.sv
hw/systolic_data_setup.sv
hw/matmul_output_logic.sv
hw/matrix_multiplication.sv
test/matrix_multiplication_sva.sv
test/tb_matrix_multiplication.sv

//--- Bender.yml
package:
  name: matrix_multiplication

sources:
  - include_dirs:
      - hw
    files:
      - hw/mat_pkg.sv
      - hw/mat_ram.sv
      - hw/processing_element.sv
      - hw/systolic_pe_matrix.sv
      - hw/systolic_data_setup.sv
      - hw/matmul_output_logic.sv
      - hw/matrix_multiplication.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/matrix_multiplication_sva.sv
      - test/tb_matrix_multiplication.sv
